/* design/l15_bridge_pkg.sv */
package l15_bridge_pkg;

  // Request queue sizing
  localparam int REQ_QUEUE_DEPTH = 4;
  localparam int REQ_QUEUE_PTR_W = $clog2(REQ_QUEUE_DEPTH);
  localparam int REQ_QUEUE_CNT_W = $clog2(REQ_QUEUE_DEPTH + 1);

  localparam logic [REQ_QUEUE_PTR_W-1:0] REQ_QUEUE_PTR_LAST =
    REQ_QUEUE_PTR_W'(REQ_QUEUE_DEPTH - 1);
  localparam logic [REQ_QUEUE_CNT_W-1:0] REQ_QUEUE_CNT_FULL =
    REQ_QUEUE_CNT_W'(REQ_QUEUE_DEPTH);

  // L1.5 request fields
  typedef logic [4:0]  l15_rqtype_t;
  typedef logic [2:0]  l15_size_t;
  typedef logic [39:0] l15_addr_t;
  typedef logic [63:0] l15_data_t;
  typedef logic [1:0]  l15_way_t;
  typedef logic [3:0]  l15_amo_op_t;

  // Invalidation address, bits 15 to 4 of the line address
  typedef logic [11:0] l15_inval_addr_t;

  // L1.5 return types
  typedef enum logic [3:0] {
    e_load_ret   = 4'd0,
    e_ifill_ret  = 4'd1,
    e_evict_req  = 4'd3,
    e_st_ack     = 4'd4,
    e_int_ret    = 4'd7,
    e_atomic_ret = 4'd13
  } l15_rtntype_e;

endpackage

/* design/l15_bridge_top.sv */
`timescale 1ns/1ps

module l15_bridge_top
  (
    input  logic                                           clk_i,
    input  logic                                           rst_i,

    // Instruction-side requests
    input  logic                                           icache_req_v_i,
    input  l15_bridge_pkg::l15_rqtype_t                    icache_req_rqtype_i,
    input  logic                                           icache_req_nc_i,
    input  l15_bridge_pkg::l15_size_t                      icache_req_size_i,
    input  l15_bridge_pkg::l15_addr_t                      icache_req_address_i,
    input  l15_bridge_pkg::l15_data_t                      icache_req_data_i,
    input  l15_bridge_pkg::l15_way_t                       icache_req_l1rplway_i,
    input  l15_bridge_pkg::l15_amo_op_t                    icache_req_amo_op_i,
    output logic                                           icache_req_ready_o,

    // Data-side requests
    input  logic                                           dcache_req_v_i,
    input  l15_bridge_pkg::l15_rqtype_t                    dcache_req_rqtype_i,
    input  logic                                           dcache_req_nc_i,
    input  l15_bridge_pkg::l15_size_t                      dcache_req_size_i,
    input  l15_bridge_pkg::l15_addr_t                      dcache_req_address_i,
    input  l15_bridge_pkg::l15_data_t                      dcache_req_data_i,
    input  l15_bridge_pkg::l15_way_t                       dcache_req_l1rplway_i,
    input  l15_bridge_pkg::l15_amo_op_t                    dcache_req_amo_op_i,
    output logic                                           dcache_req_ready_o,

    // Requests to the L1.5
    output logic                                           transducer_l15_val_o,
    output l15_bridge_pkg::l15_rqtype_t                    transducer_l15_rqtype_o,
    output logic                                           transducer_l15_nc_o,
    output l15_bridge_pkg::l15_size_t                      transducer_l15_size_o,
    output l15_bridge_pkg::l15_addr_t                      transducer_l15_address_o,
    output l15_bridge_pkg::l15_data_t                      transducer_l15_data_o,
    output l15_bridge_pkg::l15_way_t                       transducer_l15_l1rplway_o,
    output l15_bridge_pkg::l15_amo_op_t                    transducer_l15_amo_op_o,
    input  logic                                           l15_transducer_ack_i,

    // Returns from the L1.5
    input  logic                                           l15_transducer_val_i,
    input  logic [$bits(l15_bridge_pkg::l15_rtntype_e)-1:0] l15_transducer_returntype_i,
    input  l15_bridge_pkg::l15_data_t                      l15_transducer_data_0_i,
    input  l15_bridge_pkg::l15_data_t                      l15_transducer_data_1_i,
    input  logic                                           l15_transducer_noncacheable_i,
    input  logic                                           l15_transducer_atomic_i,
    input  l15_bridge_pkg::l15_inval_addr_t                l15_transducer_inval_address_15_4_i,
    input  logic                                           l15_transducer_inval_icache_inval_i,
    input  logic                                           l15_transducer_inval_dcache_inval_i,
    input  logic                                           l15_transducer_inval_icache_all_way_i,
    input  logic                                           l15_transducer_inval_dcache_all_way_i,
    input  l15_bridge_pkg::l15_way_t                       l15_transducer_inval_way_i,
    output logic                                           transducer_l15_req_ack_o,

    // Returns to the clients
    input  logic                                           icache_ret_ready_i,
    input  logic                                           dcache_ret_ready_i,
    output logic                                           icache_ret_v_o,
    output logic                                           dcache_ret_v_o,
    output l15_bridge_pkg::l15_rtntype_e                   ret_rtntype_o,
    output l15_bridge_pkg::l15_data_t                      ret_data_0_o,
    output l15_bridge_pkg::l15_data_t                      ret_data_1_o,
    output logic                                           ret_noncacheable_o,
    output logic                                           ret_atomic_o,
    output l15_bridge_pkg::l15_inval_addr_t                ret_inval_address_15_4_o,
    output l15_bridge_pkg::l15_way_t                       ret_inval_way_o
  );
  import l15_bridge_pkg::*;

  l15_req_if icache_req_q ();
  l15_req_if dcache_req_q ();

  l15_rtntype_e rtntype;

  l15_req_queue u_icache_queue (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .v_i        (icache_req_v_i),
    .rqtype_i   (icache_req_rqtype_i),
    .nc_i       (icache_req_nc_i),
    .size_i     (icache_req_size_i),
    .address_i  (icache_req_address_i),
    .data_i     (icache_req_data_i),
    .l1rplway_i (icache_req_l1rplway_i),
    .amo_op_i   (icache_req_amo_op_i),
    .ready_o    (icache_req_ready_o),
    .deq        (icache_req_q.producer)
  );

  l15_req_queue u_dcache_queue (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .v_i        (dcache_req_v_i),
    .rqtype_i   (dcache_req_rqtype_i),
    .nc_i       (dcache_req_nc_i),
    .size_i     (dcache_req_size_i),
    .address_i  (dcache_req_address_i),
    .data_i     (dcache_req_data_i),
    .l1rplway_i (dcache_req_l1rplway_i),
    .amo_op_i   (dcache_req_amo_op_i),
    .ready_o    (dcache_req_ready_o),
    .deq        (dcache_req_q.producer)
  );

  l15_req_arbiter u_req_arbiter (
    .icache_q       (icache_req_q.consumer),
    .dcache_q       (dcache_req_q.consumer),
    .l15_ack_i      (l15_transducer_ack_i),
    .l15_val_o      (transducer_l15_val_o),
    .l15_rqtype_o   (transducer_l15_rqtype_o),
    .l15_nc_o       (transducer_l15_nc_o),
    .l15_size_o     (transducer_l15_size_o),
    .l15_address_o  (transducer_l15_address_o),
    .l15_data_o     (transducer_l15_data_o),
    .l15_l1rplway_o (transducer_l15_l1rplway_o),
    .l15_amo_op_o   (transducer_l15_amo_op_o)
  );

  assign rtntype = l15_rtntype_e'(l15_transducer_returntype_i);

  l15_ret_router u_ret_router (
    .l15_val_i              (l15_transducer_val_i),
    .l15_rtntype_i          (rtntype),
    .inval_icache_inval_i   (l15_transducer_inval_icache_inval_i),
    .inval_icache_all_way_i (l15_transducer_inval_icache_all_way_i),
    .inval_dcache_inval_i   (l15_transducer_inval_dcache_inval_i),
    .inval_dcache_all_way_i (l15_transducer_inval_dcache_all_way_i),
    .icache_ret_ready_i     (icache_ret_ready_i),
    .dcache_ret_ready_i     (dcache_ret_ready_i),
    .icache_ret_v_o         (icache_ret_v_o),
    .dcache_ret_v_o         (dcache_ret_v_o),
    .l15_req_ack_o          (transducer_l15_req_ack_o)
  );

  // Return payload is shared by both clients
  assign ret_rtntype_o            = rtntype;
  assign ret_data_0_o             = l15_transducer_data_0_i;
  assign ret_data_1_o             = l15_transducer_data_1_i;
  assign ret_noncacheable_o       = l15_transducer_noncacheable_i;
  assign ret_atomic_o             = l15_transducer_atomic_i;
  assign ret_inval_address_15_4_o = l15_transducer_inval_address_15_4_i;
  assign ret_inval_way_o          = l15_transducer_inval_way_i;

endmodule

/* design/l15_req_arbiter.sv */
`timescale 1ns/1ps

module l15_req_arbiter
  (
    l15_req_if.consumer                 icache_q,
    l15_req_if.consumer                 dcache_q,

    input  logic                        l15_ack_i,
    output logic                        l15_val_o,
    output l15_bridge_pkg::l15_rqtype_t l15_rqtype_o,
    output logic                        l15_nc_o,
    output l15_bridge_pkg::l15_size_t   l15_size_o,
    output l15_bridge_pkg::l15_addr_t   l15_address_o,
    output l15_bridge_pkg::l15_data_t   l15_data_o,
    output l15_bridge_pkg::l15_way_t    l15_l1rplway_o,
    output l15_bridge_pkg::l15_amo_op_t l15_amo_op_o
  );

  logic grant_dcache;
  logic grant_icache;

  // Data side always wins when it has an entry
  always_comb
  begin
    grant_dcache  = dcache_q.v;
    grant_icache  = icache_q.v & ~dcache_q.v;
    dcache_q.yumi = grant_dcache & l15_ack_i;
    icache_q.yumi = grant_icache & l15_ack_i;
    assert ($onehot0({icache_q.yumi, dcache_q.yumi}))
      else $error("Both request queues dequeued in one cycle");
  end

  assign l15_val_o = icache_q.v | dcache_q.v;

  always_comb
  begin
    if (grant_dcache)
    begin
      l15_rqtype_o   = dcache_q.rqtype;
      l15_nc_o       = dcache_q.nc;
      l15_size_o     = dcache_q.size;
      l15_address_o  = dcache_q.address;
      l15_data_o     = dcache_q.data;
      l15_l1rplway_o = dcache_q.l1rplway;
      l15_amo_op_o   = dcache_q.amo_op;
    end
    else
    begin
      l15_rqtype_o   = icache_q.rqtype;
      l15_nc_o       = icache_q.nc;
      l15_size_o     = icache_q.size;
      l15_address_o  = icache_q.address;
      l15_data_o     = icache_q.data;
      l15_l1rplway_o = icache_q.l1rplway;
      l15_amo_op_o   = icache_q.amo_op;
    end
  end

endmodule

/* design/l15_req_if.sv */
`timescale 1ns/1ps

interface l15_req_if;
  import l15_bridge_pkg::*;

  l15_rqtype_t rqtype;
  logic        nc;
  l15_size_t   size;
  l15_addr_t   address;
  l15_data_t   data;
  l15_way_t    l1rplway;
  l15_amo_op_t amo_op;

  // Head entry valid, and its removal by the consumer
  logic        v;
  logic        yumi;

  modport producer (
    output rqtype, nc, size, address, data, l1rplway, amo_op,
    output v,
    input  yumi
  );

  modport consumer (
    input  rqtype, nc, size, address, data, l1rplway, amo_op,
    input  v,
    output yumi
  );

endinterface

/* design/l15_req_queue.sv */
`timescale 1ns/1ps

module l15_req_queue
  (
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic                        v_i,
    input  l15_bridge_pkg::l15_rqtype_t rqtype_i,
    input  logic                        nc_i,
    input  l15_bridge_pkg::l15_size_t   size_i,
    input  l15_bridge_pkg::l15_addr_t   address_i,
    input  l15_bridge_pkg::l15_data_t   data_i,
    input  l15_bridge_pkg::l15_way_t    l1rplway_i,
    input  l15_bridge_pkg::l15_amo_op_t amo_op_i,
    output logic                        ready_o,

    l15_req_if.producer                 deq
  );
  import l15_bridge_pkg::*;

  l15_rqtype_t rqtype_mem   [REQ_QUEUE_DEPTH];
  logic        nc_mem       [REQ_QUEUE_DEPTH];
  l15_size_t   size_mem     [REQ_QUEUE_DEPTH];
  l15_addr_t   address_mem  [REQ_QUEUE_DEPTH];
  l15_data_t   data_mem     [REQ_QUEUE_DEPTH];
  l15_way_t    l1rplway_mem [REQ_QUEUE_DEPTH];
  l15_amo_op_t amo_op_mem   [REQ_QUEUE_DEPTH];

  logic [REQ_QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [REQ_QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [REQ_QUEUE_CNT_W-1:0] count_q;

  logic wr_en;
  logic rd_en;

  // Ready looks at the stored count only, never at a same-cycle dequeue
  assign ready_o = (count_q != REQ_QUEUE_CNT_FULL);
  assign wr_en   = v_i & ready_o;
  assign rd_en   = deq.yumi;

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      rqtype_mem[wr_ptr_q]   <= rqtype_i;
      nc_mem[wr_ptr_q]       <= nc_i;
      size_mem[wr_ptr_q]     <= size_i;
      address_mem[wr_ptr_q]  <= address_i;
      data_mem[wr_ptr_q]     <= data_i;
      l1rplway_mem[wr_ptr_q] <= l1rplway_i;
      amo_op_mem[wr_ptr_q]   <= amo_op_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= (wr_ptr_q == REQ_QUEUE_PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= (rd_ptr_q == REQ_QUEUE_PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      unique case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head entry, visible the cycle after it is written
  assign deq.v        = (count_q != '0);
  assign deq.rqtype   = rqtype_mem[rd_ptr_q];
  assign deq.nc       = nc_mem[rd_ptr_q];
  assign deq.size     = size_mem[rd_ptr_q];
  assign deq.address  = address_mem[rd_ptr_q];
  assign deq.data     = data_mem[rd_ptr_q];
  assign deq.l1rplway = l1rplway_mem[rd_ptr_q];
  assign deq.amo_op   = amo_op_mem[rd_ptr_q];

  // Full and empty both leave the write pointer on the head
  a_ptr_count_match: assert property (@(posedge clk_i) disable iff (rst_i)
    (count_q == '0 || count_q == REQ_QUEUE_CNT_FULL) |-> (wr_ptr_q == rd_ptr_q))
    else $error("Request queue pointers disagree with its count");

  // The arbiter may only remove an entry that is there
  a_no_yumi_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    deq.yumi |-> deq.v)
    else $error("Request queue dequeued while empty");

endmodule

/* design/l15_ret_router.sv */
`timescale 1ns/1ps

module l15_ret_router
  (
    input  logic                         l15_val_i,
    input  l15_bridge_pkg::l15_rtntype_e l15_rtntype_i,

    input  logic                         inval_icache_inval_i,
    input  logic                         inval_icache_all_way_i,
    input  logic                         inval_dcache_inval_i,
    input  logic                         inval_dcache_all_way_i,

    input  logic                         icache_ret_ready_i,
    input  logic                         dcache_ret_ready_i,
    output logic                         icache_ret_v_o,
    output logic                         dcache_ret_v_o,

    output logic                         l15_req_ack_o
  );
  import l15_bridge_pkg::*;

  logic icache_type;
  logic dcache_type;
  logic icache_inval;
  logic dcache_inval;

  // Return types owned by each side; interrupts go to both
  assign icache_type = l15_rtntype_i inside {e_int_ret, e_ifill_ret};
  assign dcache_type = l15_rtntype_i inside {e_int_ret, e_load_ret, e_st_ack, e_atomic_ret};

  assign icache_inval = inval_icache_inval_i | inval_icache_all_way_i;
  assign dcache_inval = inval_dcache_inval_i | inval_dcache_all_way_i;

  always_comb
  begin
    icache_ret_v_o = l15_val_i & (icache_inval | icache_type);
    dcache_ret_v_o = l15_val_i & (dcache_inval | dcache_type);

    // Both sides must be able to take it, since an invalidation may hit both
    l15_req_ack_o = icache_ret_ready_i & dcache_ret_ready_i
                    & (icache_ret_v_o | dcache_ret_v_o);

    assert (!l15_req_ack_o || l15_val_i)
      else $error("Return acknowledged with no valid return");
  end

endmodule

/* flist.f */
design/l15_bridge_pkg.sv
design/l15_req_if.sv
design/l15_req_queue.sv
design/l15_req_arbiter.sv
design/l15_ret_router.sv
design/l15_bridge_top.sv
verif/tb_clk_gen.sv
verif/tb_l15_bridge.sv

/* run.sh */
#!/bin/sh
# Build and run the L1.5 bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_l15_bridge \
  -f flist.f -o sim_tb_l15_bridge

./obj_dir/sim_tb_l15_bridge | tee sim.log

grep -q "^Result: PASSED$" sim.log

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
  (
    output logic clk_o,
    output logic rst_o
  );

  localparam int RESET_CYCLES = 10;

  // 4 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

/* verif/tb_l15_bridge.sv */
`timescale 1ns/1ps

module tb_l15_bridge;
  import l15_bridge_pkg::*;

  typedef struct packed {
    l15_rqtype_t rqtype;
    logic        nc;
    l15_size_t   size;
    l15_addr_t   address;
    l15_data_t   data;
    l15_way_t    l1rplway;
    l15_amo_op_t amo_op;
  } req_t;

  localparam int IONLY_CYCLES  = 800;
  localparam int MIXED_CYCLES  = 1500;
  localparam int BACKPR_CYCLES = 40;
  localparam int RET_CYCLES    = 600;
  localparam int INVAL_CYCLES  = 20;
  localparam int CYCLE_LIMIT   =
    2 * (IONLY_CYCLES + MIXED_CYCLES + BACKPR_CYCLES + RET_CYCLES + INVAL_CYCLES);

  logic clk_i, rst_i;
  logic icache_req_v_i, icache_req_nc_i, icache_req_ready_o;
  logic dcache_req_v_i, dcache_req_nc_i, dcache_req_ready_o;
  logic transducer_l15_val_o, transducer_l15_nc_o, l15_transducer_ack_i;
  logic l15_transducer_val_i, l15_transducer_noncacheable_i, l15_transducer_atomic_i;
  logic l15_transducer_inval_icache_inval_i, l15_transducer_inval_icache_all_way_i;
  logic l15_transducer_inval_dcache_inval_i, l15_transducer_inval_dcache_all_way_i;
  logic transducer_l15_req_ack_o, ret_noncacheable_o, ret_atomic_o;
  logic icache_ret_ready_i, dcache_ret_ready_i, icache_ret_v_o, dcache_ret_v_o;
  l15_rqtype_t icache_req_rqtype_i, dcache_req_rqtype_i, transducer_l15_rqtype_o;
  l15_size_t   icache_req_size_i, dcache_req_size_i, transducer_l15_size_o;
  l15_addr_t   icache_req_address_i, dcache_req_address_i, transducer_l15_address_o;
  l15_data_t   icache_req_data_i, dcache_req_data_i, transducer_l15_data_o;
  l15_data_t   l15_transducer_data_0_i, l15_transducer_data_1_i, ret_data_0_o, ret_data_1_o;
  l15_way_t    icache_req_l1rplway_i, dcache_req_l1rplway_i, transducer_l15_l1rplway_o;
  l15_way_t    l15_transducer_inval_way_i, ret_inval_way_o;
  l15_amo_op_t icache_req_amo_op_i, dcache_req_amo_op_i, transducer_l15_amo_op_o;
  l15_inval_addr_t l15_transducer_inval_address_15_4_i, ret_inval_address_15_4_o;
  logic [3:0]      l15_transducer_returntype_i;
  l15_rtntype_e    ret_rtntype_o;

  l15_rtntype_e rtn_types [6] =
    '{e_load_ret, e_ifill_ret, e_evict_req, e_st_ack, e_int_ret, e_atomic_ret};

  req_t icache_pend, dcache_pend, l15_req_out;
  req_t icache_model [$];
  req_t dcache_model [$];
  logic icache_acc, dcache_acc;
  int   icache_sent, icache_left, dcache_sent, dcache_left;
  int   err_count = 0;
  int   test_err_start = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   cycles = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_o(rst_i));

  l15_bridge_top u_l15_bridge_top (.*);

  assign {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i, icache_req_address_i,
          icache_req_data_i, icache_req_l1rplway_i, icache_req_amo_op_i} = icache_pend;
  assign {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i, dcache_req_address_i,
          dcache_req_data_i, dcache_req_l1rplway_i, dcache_req_amo_op_i} = dcache_pend;
  assign l15_req_out = {transducer_l15_rqtype_o, transducer_l15_nc_o, transducer_l15_size_o,
                        transducer_l15_address_o, transducer_l15_data_o,
                        transducer_l15_l1rplway_o, transducer_l15_amo_op_o};

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic req_t random_req();
    req_t r;
    r.rqtype   = 5'($urandom);
    r.nc       = 1'($urandom);
    r.size     = 3'($urandom);
    r.address  = 40'({$urandom, $urandom});
    r.data     = {$urandom, $urandom};
    r.l1rplway = 2'($urandom);
    r.amo_op   = 4'($urandom);
    return r;
  endfunction

  // Return types that each client takes; interrupts go to both
  function automatic logic icache_wants(input logic [3:0] t);
    return (t == e_ifill_ret) || (t == e_int_ret);
  endfunction

  function automatic logic dcache_wants(input logic [3:0] t);
    return (t == e_load_ret) || (t == e_st_ack) || (t == e_atomic_ret) || (t == e_int_ret);
  endfunction

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp)
    begin
      err_count++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  task automatic check_req(input req_t got, input req_t exp);
    compare_field("transducer_l15_rqtype_o", 64'(got.rqtype), 64'(exp.rqtype));
    compare_field("transducer_l15_nc_o", 64'(got.nc), 64'(exp.nc));
    compare_field("transducer_l15_size_o", 64'(got.size), 64'(exp.size));
    compare_field("transducer_l15_address_o", 64'(got.address), 64'(exp.address));
    compare_field("transducer_l15_data_o", got.data, exp.data);
    compare_field("transducer_l15_l1rplway_o", 64'(got.l1rplway), 64'(exp.l1rplway));
    compare_field("transducer_l15_amo_op_o", 64'(got.amo_op), 64'(exp.amo_op));
  endtask

  task automatic check_ret_v(input string name, input logic got, input logic exp);
    compare_field(name, 64'(got), 64'(exp));
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    compare_field(name, 64'(got), 64'(exp));
  endtask

  task automatic check_ret_payload();
    compare_field("ret_rtntype_o", 64'(ret_rtntype_o), 64'(l15_transducer_returntype_i));
    compare_field("ret_data_0_o", ret_data_0_o, l15_transducer_data_0_i);
    compare_field("ret_data_1_o", ret_data_1_o, l15_transducer_data_1_i);
    compare_field("ret_noncacheable_o", 64'(ret_noncacheable_o),
                  64'(l15_transducer_noncacheable_i));
    compare_field("ret_atomic_o", 64'(ret_atomic_o), 64'(l15_transducer_atomic_i));
    compare_field("ret_inval_address_15_4_o", 64'(ret_inval_address_15_4_o),
                  64'(l15_transducer_inval_address_15_4_i));
    compare_field("ret_inval_way_o", 64'(ret_inval_way_o), 64'(l15_transducer_inval_way_i));
  endtask

  // Checks mid-cycle, then steps the model across the next rising edge
  task automatic run_cycle();
    logic exp_icache_v;
    logic exp_dcache_v;
    #2;
    check_ready("icache_req_ready_o", icache_req_ready_o, icache_model.size() < REQ_QUEUE_DEPTH);
    check_ready("dcache_req_ready_o", dcache_req_ready_o, dcache_model.size() < REQ_QUEUE_DEPTH);
    check_ready("transducer_l15_val_o", transducer_l15_val_o,
                (icache_model.size() + dcache_model.size()) != 0);
    if (dcache_model.size() != 0)
      check_req(l15_req_out, dcache_model[0]);
    else if (icache_model.size() != 0)
      check_req(l15_req_out, icache_model[0]);
    exp_icache_v = l15_transducer_val_i & (l15_transducer_inval_icache_inval_i
                   | l15_transducer_inval_icache_all_way_i
                   | icache_wants(l15_transducer_returntype_i));
    exp_dcache_v = l15_transducer_val_i & (l15_transducer_inval_dcache_inval_i
                   | l15_transducer_inval_dcache_all_way_i
                   | dcache_wants(l15_transducer_returntype_i));
    check_ret_v("icache_ret_v_o", icache_ret_v_o, exp_icache_v);
    check_ret_v("dcache_ret_v_o", dcache_ret_v_o, exp_dcache_v);
    check_ret_v("transducer_l15_req_ack_o", transducer_l15_req_ack_o,
                icache_ret_ready_i & dcache_ret_ready_i & (exp_icache_v | exp_dcache_v));
    check_ret_payload();
    icache_acc = icache_req_v_i && (icache_model.size() < REQ_QUEUE_DEPTH);
    dcache_acc = dcache_req_v_i && (dcache_model.size() < REQ_QUEUE_DEPTH);
    // Handshakes as the DUT sees them
    if (icache_req_v_i && icache_req_ready_o)
      icache_sent++;
    if (dcache_req_v_i && dcache_req_ready_o)
      dcache_sent++;
    if (transducer_l15_val_o && l15_transducer_ack_i)
    begin
      if (dcache_model.size() != 0)
        dcache_left++;
      else
        icache_left++;
    end
    @(posedge clk_i);
    if (l15_transducer_ack_i && dcache_model.size() != 0)
      void'(dcache_model.pop_front());
    else if (l15_transducer_ack_i && icache_model.size() != 0)
      void'(icache_model.pop_front());
    if (icache_acc)
      icache_model.push_back(icache_pend);
    if (dcache_acc)
      dcache_model.push_back(dcache_pend);
    #1;
  endtask

  // A request that was not taken stays on the port unchanged
  task automatic drive_clients(input logic icache_en, input logic dcache_en,
                               input int ack_pct);
    if (!icache_req_v_i || icache_acc)
    begin
      icache_req_v_i = icache_en && (($urandom % 3) != 0);
      icache_pend    = random_req();
    end
    if (!dcache_req_v_i || dcache_acc)
    begin
      dcache_req_v_i = dcache_en && (($urandom % 3) != 0);
      dcache_pend    = random_req();
    end
    l15_transducer_ack_i = ($urandom % 100) < ack_pct;
  endtask

  task automatic drive_returns();
    int idx;
    idx = $urandom % 6;
    l15_transducer_val_i                  = ($urandom % 4) != 0;
    l15_transducer_returntype_i           = rtn_types[idx];
    l15_transducer_data_0_i               = {$urandom, $urandom};
    l15_transducer_data_1_i               = {$urandom, $urandom};
    l15_transducer_noncacheable_i         = 1'($urandom);
    l15_transducer_atomic_i               = 1'($urandom);
    l15_transducer_inval_address_15_4_i   = 12'($urandom);
    l15_transducer_inval_way_i            = 2'($urandom);
    l15_transducer_inval_icache_inval_i   = ($urandom % 5) == 0;
    l15_transducer_inval_icache_all_way_i = ($urandom % 8) == 0;
    l15_transducer_inval_dcache_inval_i   = ($urandom % 5) == 0;
    l15_transducer_inval_dcache_all_way_i = ($urandom % 8) == 0;
    icache_ret_ready_i                    = ($urandom % 3) != 0;
    dcache_ret_ready_i                    = ($urandom % 3) != 0;
  endtask

  task automatic drain_queues();
    icache_req_v_i       = 1'b0;
    dcache_req_v_i       = 1'b0;
    l15_transducer_ack_i = 1'b1;
    while ((icache_model.size() + dcache_model.size()) != 0)
      run_cycle();
    run_cycle();
    l15_transducer_ack_i = 1'b0;
  endtask

  task automatic check_counts();
    compare_field("icache requests dequeued", 64'(icache_left), 64'(icache_sent));
    compare_field("dcache requests dequeued", 64'(dcache_left), 64'(dcache_sent));
  endtask

  task automatic start_test();
    test_err_start = err_count;
    icache_sent    = 0;
    icache_left    = 0;
    dcache_sent    = 0;
    dcache_left    = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == test_err_start)
      $display("Test %0d, %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d, %s: %0d errors", tests_run, name, err_count - test_err_start);
    end
  endtask

  initial
  begin
    int i;
    void'($urandom(18187));
    icache_req_v_i       = 1'b0;
    dcache_req_v_i       = 1'b0;
    icache_pend          = '0;
    dcache_pend          = '0;
    icache_acc           = 1'b0;
    dcache_acc           = 1'b0;
    l15_transducer_ack_i = 1'b0;
    l15_transducer_val_i                  = 1'b0;
    l15_transducer_returntype_i           = '0;
    l15_transducer_data_0_i               = '0;
    l15_transducer_data_1_i               = '0;
    l15_transducer_noncacheable_i         = 1'b0;
    l15_transducer_atomic_i               = 1'b0;
    l15_transducer_inval_address_15_4_i   = '0;
    l15_transducer_inval_way_i            = '0;
    l15_transducer_inval_icache_inval_i   = 1'b0;
    l15_transducer_inval_icache_all_way_i = 1'b0;
    l15_transducer_inval_dcache_inval_i   = 1'b0;
    l15_transducer_inval_dcache_all_way_i = 1'b0;
    icache_ret_ready_i                    = 1'b1;
    dcache_ret_ready_i                    = 1'b1;
    @(negedge rst_i);

    start_test();
    repeat (3) run_cycle();
    end_test("state after reset");

    start_test();
    repeat (IONLY_CYCLES)
    begin
      drive_clients(1'b1, 1'b0, 60);
      run_cycle();
    end
    drain_queues();
    check_counts();
    end_test("instruction-only stream");

    start_test();
    repeat (MIXED_CYCLES)
    begin
      drive_clients(1'b1, 1'b1, 50);
      run_cycle();
    end
    drain_queues();
    check_counts();
    end_test("mixed stream with data priority");

    // Both queues fill while the L1.5 gives no ack
    start_test();
    icache_req_v_i = 1'b1;
    dcache_req_v_i = 1'b1;
    repeat (REQ_QUEUE_DEPTH + 2)
    begin
      run_cycle();
      if (icache_acc)
        icache_pend = random_req();
      if (dcache_acc)
        dcache_pend = random_req();
    end
    compare_field("icache requests accepted while stalled", 64'(icache_sent),
                  64'(REQ_QUEUE_DEPTH));
    compare_field("dcache requests accepted while stalled", 64'(dcache_sent),
                  64'(REQ_QUEUE_DEPTH));
    check_ready("icache_req_ready_o", icache_req_ready_o, 1'b0);
    check_ready("dcache_req_ready_o", dcache_req_ready_o, 1'b0);
    l15_transducer_ack_i = 1'b1;
    run_cycle();
    check_ready("dcache_req_ready_o", dcache_req_ready_o, 1'b1);
    check_ready("icache_req_ready_o", icache_req_ready_o, 1'b0);
    dcache_req_v_i = 1'b0;
    while (dcache_model.size() != 0)
      run_cycle();
    run_cycle();
    l15_transducer_ack_i = 1'b0;
    check_ready("icache_req_ready_o", icache_req_ready_o, 1'b1);
    drain_queues();
    end_test("queue full back-pressure");

    start_test();
    repeat (RET_CYCLES)
    begin
      drive_returns();
      run_cycle();
    end
    end_test("return routing and payload");

    // An invalidation for both sides waits until both can take it
    start_test();
    l15_transducer_val_i                  = 1'b1;
    l15_transducer_returntype_i           = e_evict_req;
    l15_transducer_inval_icache_inval_i   = 1'b1;
    l15_transducer_inval_dcache_inval_i   = 1'b1;
    l15_transducer_inval_icache_all_way_i = 1'b0;
    l15_transducer_inval_dcache_all_way_i = 1'b0;
    for (i = 0; i < INVAL_CYCLES - 1; i++)
    begin
      icache_ret_ready_i = i[0];
      dcache_ret_ready_i = !i[0];
      run_cycle();
      check_ret_v("transducer_l15_req_ack_o", transducer_l15_req_ack_o, 1'b0);
    end
    icache_ret_ready_i = 1'b1;
    dcache_ret_ready_i = 1'b1;
    run_cycle();
    check_ret_v("transducer_l15_req_ack_o", transducer_l15_req_ack_o, 1'b1);
    l15_transducer_val_i = 1'b0;
    end_test("invalidation with one client ready");

    $display("Tests: %0d run, %0d failed, %0d mismatches", tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
